//--- hdl/cpu_config.svh
////////////////////////////////////////////////////////////
// Core sizing macros. IMEM depth must cover the 8-bit PC
// and DMEM depth must match the 6-bit immediate address
////////////////////////////////////////////////////////////
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Width of a data word and of every register
`define CPU_DATA_W 8

// Architectural register count, indexed by a 3-bit field
`define CPU_NUM_REGS 8

// Instruction words reachable by the PC
`define CPU_IMEM_DEPTH 256

// Data words reachable by LD/ST immediates
`define CPU_DMEM_DEPTH 64

`endif

//--- hdl/cpu_pkg.sv
////////////////////////////////////////////////////////////
// Shared types. Instruction is {op[15:12], rd, rs, imm6}
////////////////////////////////////////////////////////////
`include "cpu_config.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_W-1:0] word_t;
    typedef logic [7:0]             pc_t;
    typedef logic [15:0]            instr_t;
    typedef logic [2:0]             reg_idx_t;
    typedef logic [5:0]             imm_t;    // Zero-extended on use

    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_ADDI = 4'd6,
        OP_LDI  = 4'd7,
        OP_LD   = 4'd8,
        OP_ST   = 4'd9,
        OP_JMP  = 4'd10,
        OP_JZ   = 4'd11,
        OP_JNZ  = 4'd12,
        OP_HALT = 4'd15
    } opcode_e;

    typedef struct packed {
        logic     en;
        pc_t      addr;
        instr_t   data;
    } imem_wr_t;

    typedef struct packed {
        logic     valid;
        pc_t      pc;
        instr_t   instr;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        opcode_e  op;
        reg_idx_t rd;
        reg_idx_t rs;
        word_t    rd_val;
        word_t    rs_val;
        imm_t     imm;
    } id_ex_t;

    // result doubles as store data for ST
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    result;
        logic     is_load;
        logic     is_store;
        logic     wr_reg;
        logic     is_halt;
        imm_t     addr;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        logic     wr_reg;
        reg_idx_t rd;
        word_t    data;
        logic     is_halt;
    } mem_wb_t;

    typedef struct packed {
        logic     valid;
        pc_t      target;
    } redirect_t;

    // Register 0 sits in the low byte
    typedef word_t [`CPU_NUM_REGS-1:0] reg_view_t;

endpackage

//--- hdl/fetch_stage.sv
////////////////////////////////////////////////////////////
// Fetch. Load port writes IMEM only while rst is high
////////////////////////////////////////////////////////////
`include "cpu_config.svh"

module fetch_stage
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  imem_wr_t  imem_wr,
    input  logic      stall,
    input  logic      halt_seen,
    input  redirect_t redirect,
    output if_id_t    if_id,
    output pc_t       pc
);

    instr_t imem [`CPU_IMEM_DEPTH];

    // Program load, core held in reset meanwhile
    always_ff @(posedge clk) begin
        if (rst && imem_wr.en) begin
            imem[imem_wr.addr] <= imem_wr.data;
        end
    end

    // Redirect wins over stall and halt
    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= '0;
            if_id.valid <= 1'b0;
        end else if (redirect.valid) begin
            pc          <= redirect.target;
            if_id.valid <= 1'b0;           // Drop the wrong-path slot
        end else if (!stall && !halt_seen) begin
            pc          <= pc + 8'd1;
            if_id.valid <= 1'b1;
        end
        if (!stall && !halt_seen) begin
            if_id.pc    <= pc;
            if_id.instr <= imem[pc];       // Payload, no reset needed
        end
    end

endmodule

//--- hdl/decode_stage.sv
////////////////////////////////////////////////////////////
// Decode and register file. Writeback is visible to a read
// in the same cycle through bypass
////////////////////////////////////////////////////////////
`include "cpu_config.svh"

module decode_stage
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  if_id_t    if_id,
    input  redirect_t redirect,
    input  mem_wb_t   wb,
    output id_ex_t    id_ex,
    output logic      stall,
    output logic      halt_seen,
    output reg_view_t regs
);

    word_t    rf [`CPU_NUM_REGS];
    opcode_e  op;
    reg_idx_t rd;
    reg_idx_t rs;
    imm_t     imm;
    word_t    rd_val;
    word_t    rs_val;
    logic     rd_used;
    logic     rs_used;
    logic     wb_wr;

    assign op  = opcode_e'(if_id.instr[15:12]);
    assign rd  = if_id.instr[11:9];
    assign rs  = if_id.instr[8:6];
    assign imm = if_id.instr[5:0];

    // Source usage per opcode, so only real dependencies stall
    assign rd_used = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                OP_ADDI, OP_ST, OP_JZ, OP_JNZ};
    assign rs_used = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};

    assign wb_wr  = wb.valid && wb.wr_reg;
    assign rd_val = (wb_wr && wb.rd == rd) ? wb.data : rf[rd];
    assign rs_val = (wb_wr && wb.rd == rs) ? wb.data : rf[rs];

    // Load in execute feeding the instruction in decode
    assign stall = if_id.valid && id_ex.valid && id_ex.op == OP_LD &&
                   ((rd_used && id_ex.rd == rd) || (rs_used && id_ex.rd == rs));

    assign halt_seen = if_id.valid && op == OP_HALT;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                rf[i] <= '0;
            end
        end else if (wb_wr) begin
            rf[wb.rd] <= wb.data;
        end
    end

    always_comb begin
        for (int i = 0; i < `CPU_NUM_REGS; i++) begin
            regs[i] = rf[i];
        end
    end

    // Bubble on stall or redirect, only valid is cleared
    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex.valid <= if_id.valid && !stall && !redirect.valid;
        end
        id_ex.op     <= op;
        id_ex.rd     <= rd;
        id_ex.rs     <= rs;
        id_ex.rd_val <= rd_val;
        id_ex.rs_val <= rs_val;
        id_ex.imm    <= imm;
    end

endmodule

//--- hdl/execute_stage.sv
////////////////////////////////////////////////////////////
// Execute. Branches resolve here, not-taken is assumed
////////////////////////////////////////////////////////////
`include "cpu_config.svh"

module execute_stage
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  id_ex_t    id_ex,
    input  mem_wb_t   wb,
    output ex_mem_t   ex_mem,
    output redirect_t redirect
);

    word_t rd_fwd;
    word_t rs_fwd;
    word_t imm_ext;
    word_t result;
    logic  mem_hit_rd;
    logic  mem_hit_rs;
    logic  wb_hit_rd;
    logic  wb_hit_rs;

    // Load data is not ready in MEM, load-use stall covers it
    assign mem_hit_rd = ex_mem.valid && ex_mem.wr_reg && !ex_mem.is_load &&
                        ex_mem.rd == id_ex.rd;
    assign mem_hit_rs = ex_mem.valid && ex_mem.wr_reg && !ex_mem.is_load &&
                        ex_mem.rd == id_ex.rs;
    assign wb_hit_rd  = wb.valid && wb.wr_reg && wb.rd == id_ex.rd;
    assign wb_hit_rs  = wb.valid && wb.wr_reg && wb.rd == id_ex.rs;

    // MEM first, then WB, then the decode-time value
    assign rd_fwd = mem_hit_rd ? ex_mem.result : wb_hit_rd ? wb.data : id_ex.rd_val;
    assign rs_fwd = mem_hit_rs ? ex_mem.result : wb_hit_rs ? wb.data : id_ex.rs_val;

    assign imm_ext = word_t'(id_ex.imm);

    always_comb begin
        case (id_ex.op)
            OP_ADD:  result = rd_fwd + rs_fwd;
            OP_SUB:  result = rd_fwd - rs_fwd;
            OP_AND:  result = rd_fwd & rs_fwd;
            OP_OR:   result = rd_fwd | rs_fwd;
            OP_XOR:  result = rd_fwd ^ rs_fwd;
            OP_ADDI: result = rd_fwd + imm_ext;
            OP_LDI:  result = imm_ext;
            OP_ST:   result = rd_fwd;          // Store data
            default: result = '0;
        endcase
    end

    assign redirect.valid  = id_ex.valid &&
                             (id_ex.op == OP_JMP ||
                              (id_ex.op == OP_JZ  && rd_fwd == '0) ||
                              (id_ex.op == OP_JNZ && rd_fwd != '0));
    assign redirect.target = pc_t'(id_ex.imm);

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem.valid <= 1'b0;
        end else begin
            ex_mem.valid <= id_ex.valid;
        end
        ex_mem.rd       <= id_ex.rd;
        ex_mem.result   <= result;
        ex_mem.is_load  <= id_ex.op == OP_LD;
        ex_mem.is_store <= id_ex.op == OP_ST;
        ex_mem.wr_reg   <= id_ex.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                            OP_ADDI, OP_LDI, OP_LD};
        ex_mem.is_halt  <= id_ex.op == OP_HALT;
        ex_mem.addr     <= id_ex.imm;
    end

endmodule

//--- hdl/memory_stage.sv
////////////////////////////////////////////////////////////
// Data memory and writeback register. Halt is sticky
////////////////////////////////////////////////////////////
`include "cpu_config.svh"

module memory_stage
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  ex_mem_t ex_mem,
    output mem_wb_t wb,
    output logic    halt
);

    word_t dmem [`CPU_DMEM_DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CPU_DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_mem.valid && ex_mem.is_store) begin
            dmem[ex_mem.addr] <= ex_mem.result;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb.valid <= 1'b0;
            halt     <= 1'b0;
        end else begin
            wb.valid <= ex_mem.valid;
            if (wb.valid && wb.is_halt) begin
                halt <= 1'b1;                // Held until reset
            end
        end
        wb.wr_reg  <= ex_mem.wr_reg;
        wb.rd      <= ex_mem.rd;
        wb.data    <= ex_mem.is_load ? dmem[ex_mem.addr] : ex_mem.result;
        wb.is_halt <= ex_mem.is_halt;
    end

endmodule

//--- hdl/cpu_top.sv
////////////////////////////////////////////////////////////
// Core top. Load the program through imem_wr under reset
////////////////////////////////////////////////////////////
`include "cpu_config.svh"

module cpu_top
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  imem_wr_t  imem_wr,
    output logic      halt,
    output pc_t       pc,
    output reg_view_t regs
);

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   wb;
    redirect_t redirect;
    logic      stall;
    logic      halt_seen;

    fetch_stage i_fetch (
        .clk       (clk),
        .rst       (rst),
        .imem_wr   (imem_wr),
        .stall     (stall),
        .halt_seen (halt_seen),
        .redirect  (redirect),
        .if_id     (if_id),
        .pc        (pc)
    );

    decode_stage i_decode (
        .clk       (clk),
        .rst       (rst),
        .if_id     (if_id),
        .redirect  (redirect),
        .wb        (wb),
        .id_ex     (id_ex),
        .stall     (stall),
        .halt_seen (halt_seen),
        .regs      (regs)
    );

    execute_stage i_execute (
        .clk      (clk),
        .rst      (rst),
        .id_ex    (id_ex),
        .wb       (wb),
        .ex_mem   (ex_mem),
        .redirect (redirect)
    );

    memory_stage i_memory (
        .clk    (clk),
        .rst    (rst),
        .ex_mem (ex_mem),
        .wb     (wb),
        .halt   (halt)
    );

endmodule

//--- bench/tb_clock.sv
////////////////////////////////////////////////////////////
// Free-running clock that starts low, reset starts high
////////////////////////////////////////////////////////////
module tb_clock #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- bench/cpu_properties.sv
////////////////////////////////////////////////////////////
// Core checks bound into cpu_top, sampled on rising clk
////////////////////////////////////////////////////////////
module cpu_properties
    import cpu_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      halt,
    input pc_t       pc,
    input logic      stall,
    input redirect_t redirect
);

    // Sticky halt, only reset clears it
    halt_sticky: assert property (@(posedge clk) (!rst && halt) |=> (halt || rst))
        else $error("halt dropped while reset was low");

    // Fetch is frozen once the core has halted
    pc_frozen: assert property (@(posedge clk) (!rst && halt) |=> ($stable(pc) || rst))
        else $error("pc moved while halt was high");

    // Pipeline is empty right after reset
    clean_start: assert property (@(posedge clk) $fell(rst) |-> (!stall && !redirect.valid))
        else $error("stall or redirect active in the first cycle after reset");

endmodule

//--- bench/cpu_tb.sv
////////////////////////////////////////////////////////////
// Random and directed programs checked against an ISA model.
// Programs end in HALT and only jump forward
////////////////////////////////////////////////////////////
module cpu_tb
    import cpu_pkg::*;
;

    localparam int RUNS_PER_MODE = 8;
    localparam int NUM_RUNS      = 1 + 3 * RUNS_PER_MODE;
    localparam int MAX_LEN       = 41;                      // 40 instructions plus HALT
    localparam int WATCHDOG_CYC  = NUM_RUNS * (MAX_LEN * 4 + 50);

    logic      clk;
    logic      boot_rst;
    logic      load_rst;
    logic      rst;
    imem_wr_t  imem_wr;
    logic      halt;
    pc_t       pc;
    reg_view_t regs;

    logic [15:0] lfsr;
    instr_t      prog [64];
    word_t       exp_regs [8];
    word_t       model_mem [64];
    int          errors;
    string       mode_names [3] = '{"alu", "memory", "branch"};

    assign rst = boot_rst | load_rst;

    tb_clock #(.PERIOD(40), .RESET_CYCLES(4)) i_clock (
        .clk (clk),
        .rst (boot_rst)
    );

    cpu_top i_dut (
        .clk     (clk),
        .rst     (rst),
        .imem_wr (imem_wr),
        .halt    (halt),
        .pc      (pc),
        .regs    (regs)
    );

    bind cpu_top cpu_properties i_props (
        .clk      (clk),
        .rst      (rst),
        .halt     (halt),
        .pc       (pc),
        .stall    (stall),
        .redirect (redirect)
    );

    // One LFSR step per bit, taps x^16+x^14+x^13+x^11
    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[6:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic instr_t encode(input opcode_e op, input int rd, input int rs,
                                      input int imm);
        return {op, reg_idx_t'(rd), reg_idx_t'(rs), imm_t'(imm)};
    endfunction

    // Back-to-back chains at distance 1..3, branch conditions, load-use
    task automatic build_directed(output int len);
        prog[0]  = encode(OP_LDI,  1, 0, 5);
        prog[1]  = encode(OP_ADDI, 1, 0, 3);
        prog[2]  = encode(OP_ADD,  2, 1, 0);
        prog[3]  = encode(OP_SUB,  3, 1, 0);
        prog[4]  = encode(OP_XOR,  4, 1, 0);
        prog[5]  = encode(OP_LDI,  5, 0, 0);
        prog[6]  = encode(OP_JZ,   5, 0, 9);    // Taken, flushes 7 and 8
        prog[7]  = encode(OP_LDI,  6, 0, 9);
        prog[8]  = encode(OP_LDI,  7, 0, 9);
        prog[9]  = encode(OP_ST,   2, 0, 4);
        prog[10] = encode(OP_LD,   6, 0, 4);
        prog[11] = encode(OP_ADD,  6, 6, 0);    // Load-use
        prog[12] = encode(OP_JNZ,  6, 0, 14);
        prog[13] = encode(OP_LDI,  7, 0, 1);
        prog[14] = encode(OP_HALT, 0, 0, 0);
        len = 14;
    endtask

    // Mode 0 ALU only, 1 adds LD/ST, 2 adds forward jumps
    task automatic build_random(input int mode, output int len);
        int      rd;
        int      rs;
        int      imm;
        int      kind;
        int      prev_rd;
        logic    prev_ld;
        opcode_e op;
        len     = 12 + int'(take_bits(5)) % 29;
        prev_ld = 1'b0;
        prev_rd = 0;
        for (int i = 0; i < len; i++) begin
            rd   = int'(take_bits(3));
            rs   = int'(take_bits(3));
            imm  = int'(take_bits(6));
            kind = int'(take_bits(2));
            op   = opcode_e'(4'(1 + int'(take_bits(3)) % 7));
            if (mode == 1) begin
                if (kind >= 2) begin
                    op  = (kind == 2) ? OP_LD : OP_ST;
                    imm = imm % 8;                       // Few addresses, more reuse
                end
                if (prev_ld && take_bits(1) == 8'd1) begin
                    op = OP_ADD;
                    rs = prev_rd;
                end
            end else if (mode == 2 && kind == 3) begin
                case (int'(take_bits(2)) % 3)
                    0:       op = OP_JMP;
                    1:       op = OP_JZ;
                    default: op = OP_JNZ;
                endcase
                imm = i + 1 + int'(take_bits(6)) % (len - i);  // Ahead, at most HALT
            end
            prev_ld = (op == OP_LD);
            prev_rd = rd;
            prog[i] = encode(op, rd, rs, imm);
        end
        prog[len] = encode(OP_HALT, 0, 0, 0);
    endtask

    // Sequential ISA model, no pipeline
    task automatic interpret_program(input int len);
        int       pcm;
        int       steps;
        logic     done;
        instr_t   w;
        opcode_e  op;
        reg_idx_t rd;
        reg_idx_t rs;
        imm_t     imm;
        for (int i = 0; i < 8; i++) exp_regs[i] = '0;
        for (int i = 0; i < 64; i++) model_mem[i] = '0;
        pcm   = 0;
        steps = 0;
        done  = 1'b0;
        while (!done && steps < 256 && pcm <= len) begin
            w   = prog[pcm];
            op  = opcode_e'(w[15:12]);
            rd  = w[11:9];
            rs  = w[8:6];
            imm = w[5:0];
            pcm++;
            steps++;
            case (op)
                OP_ADD:  exp_regs[rd] = exp_regs[rd] + exp_regs[rs];
                OP_SUB:  exp_regs[rd] = exp_regs[rd] - exp_regs[rs];
                OP_AND:  exp_regs[rd] = exp_regs[rd] & exp_regs[rs];
                OP_OR:   exp_regs[rd] = exp_regs[rd] | exp_regs[rs];
                OP_XOR:  exp_regs[rd] = exp_regs[rd] ^ exp_regs[rs];
                OP_ADDI: exp_regs[rd] = exp_regs[rd] + word_t'(imm);
                OP_LDI:  exp_regs[rd] = word_t'(imm);
                OP_LD:   exp_regs[rd] = model_mem[imm];
                OP_ST:   model_mem[imm] = exp_regs[rd];
                OP_JMP:  pcm = int'(imm);
                OP_JZ:   if (exp_regs[rd] == '0) pcm = int'(imm);
                OP_JNZ:  if (exp_regs[rd] != '0) pcm = int'(imm);
                OP_HALT: done = 1'b1;
                default: ;
            endcase
        end
    endtask

    task automatic load_and_run(input string name, input int len);
        pc_t held_pc;
        interpret_program(len);
        @(posedge clk);
        load_rst <= 1'b1;
        for (int a = 0; a <= len; a++) begin
            @(posedge clk);
            imem_wr <= '{en: 1'b1, addr: pc_t'(a), data: prog[a]};
        end
        @(posedge clk);
        imem_wr <= '0;
        @(posedge clk);
        load_rst <= 1'b0;
        @(negedge clk);
        while (!halt) @(negedge clk);                    // Watchdog bounds this
        for (int r = 0; r < 8; r++) begin
            if (regs[r] != exp_regs[r]) begin
                $display("error %s: r%0d expected %0d actual %0d", name, r, exp_regs[r],
                         regs[r]);
                errors++;
            end
        end
        held_pc = pc;
        repeat (20) begin
            @(negedge clk);
            for (int r = 0; r < 8; r++) begin
                if (regs[r] != exp_regs[r]) begin
                    $display("error %s: r%0d after halt expected %0d actual %0d", name, r,
                             exp_regs[r], regs[r]);
                    errors++;
                end
            end
            if (pc != held_pc) begin
                $display("error %s: pc after halt expected %0d actual %0d", name, held_pc, pc);
                errors++;
            end
        end
    endtask

    initial begin
        int len;
        lfsr     = 16'd42;
        errors   = 0;
        load_rst = 1'b1;
        imem_wr  = '0;
        build_directed(len);
        load_and_run("forwarding", len);
        for (int m = 0; m < 3; m++) begin
            for (int k = 0; k < RUNS_PER_MODE; k++) begin
                build_random(m, len);
                load_and_run($sformatf("%s_%0d", mode_names[m], k), len);
            end
        end
        $display("%0d errors", errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYC * 40);
        $display("timeout: the core did not halt within the cycle budget");
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- files.f
+incdir+hdl
hdl/cpu_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/cpu_top.sv
bench/tb_clock.sv
bench/cpu_properties.sv
bench/cpu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the log holds the pass line
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cpu_tb -f files.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vcpu_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^>>> PASS$' sim.log; then
    exit 0
fi
exit 1
